//--- ams/ams_regs.sv
// --------------------
// pwm duty registers of the slow analog block
// --------------------
`timescale 1ns/100ps
`include "rp_defines.svh"

module ams_regs (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  reg_bus_if.slv            bus,
  output rp_pkg::pwm_duty_t duty_o [`RP_PWM_N]
);

  localparam int IDX_W = $clog2(`RP_PWM_N);

  rp_pkg::reg_offs_t rel;  // offset from the first duty reg
  logic [IDX_W-1:0]  idx;  // channel number
  logic              hit;

  assign rel = bus.offs - `RP_AMS_DUTY_OFS;
  assign idx = rel[2 +: IDX_W];
  assign hit = (rel[1:0] == 2'b00) && (rel[`RP_OFFS_W-1:2] < `RP_PWM_N);  // word aligned, in range

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
      for (int i = 0; i < `RP_PWM_N; i++) duty_o[i] <= '0;
    end else begin
      bus.ack <= bus.wen | bus.ren;
      bus.err <= (bus.wen | bus.ren) & ~hit;
      if (bus.wen && hit) duty_o[idx] <= bus.wdata[`RP_PWM_W-1:0];
    end
  end

  // readback
  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      if (hit) bus.rdata <= {{(`RP_DATA_W-`RP_PWM_W){1'b0}}, duty_o[idx]};
      else     bus.rdata <= '0;
    end
  end

endmodule

//--- ams/pwm_gen.sv
// --------------------
// one pwm channel, 256 cycle period
// --------------------
`timescale 1ns/100ps
`include "rp_defines.svh"

module pwm_gen (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  input  rp_pkg::pwm_duty_t duty_i,
  output logic              pwm_o
);

  logic [`RP_PWM_W-1:0] cnt_q;   // free running
  rp_pkg::pwm_duty_t    duty_q;  // duty of the running period

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      duty_q <= '0;
      pwm_o  <= 1'b0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
      if (&cnt_q) duty_q <= duty_i;  // new duty only at wrap
      pwm_o <= (cnt_q < duty_q);     // high for duty cycles per period
    end
  end

endmodule

//--- analog/adc_frontend.sv
// --------------------
// adc input registers, neg slope code to two's complement, loop select
// --------------------
`timescale 1ns/100ps
`include "rp_defines.svh"

module adc_frontend (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  input  rp_pkg::adc_code_t adc_dat_a_i,
  input  rp_pkg::adc_code_t adc_dat_b_i,
  input  logic              digital_loop_i,
  input  rp_pkg::sample_t   dac_a_i,
  input  rp_pkg::sample_t   dac_b_i,
  output rp_pkg::sample_t   adc_a_o,
  output rp_pkg::sample_t   adc_b_o
);

  // code of a zero sample, msb low and the rest high
  localparam rp_pkg::adc_code_t ZERO_CODE = {1'b0, {(`RP_ADC_W-1){1'b1}}};

  rp_pkg::adc_code_t adc_a_q, adc_b_q;

  // pin registers
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      adc_a_q <= ZERO_CODE;
      adc_b_q <= ZERO_CODE;
    end else begin
      adc_a_q <= adc_dat_a_i;
      adc_b_q <= adc_dat_b_i;
    end
  end

  // keep msb, invert the rest
  assign adc_a_o = digital_loop_i ? dac_a_i : {adc_a_q[`RP_ADC_W-1], ~adc_a_q[`RP_ADC_W-2:0]};
  assign adc_b_o = digital_loop_i ? dac_b_i : {adc_b_q[`RP_ADC_W-1], ~adc_b_q[`RP_ADC_W-2:0]};

endmodule

//--- analog/dac_backend.sv
// --------------------
// dac back end: dc level plus adc feed-through, clip to 14 bit, dac code
// --------------------
`timescale 1ns/100ps
`include "rp_defines.svh"

module dac_backend (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  reg_bus_if.slv            bus,
  input  rp_pkg::sample_t   adc_a_i,
  input  rp_pkg::sample_t   adc_b_i,
  output rp_pkg::sample_t   dac_a_o,      // registered, also the loop source
  output rp_pkg::sample_t   dac_b_o,
  output rp_pkg::adc_code_t dac_dat_a_o,
  output rp_pkg::adc_code_t dac_dat_b_o
);

  rp_pkg::sample_t  lvl_a_q, lvl_b_q;  // dc levels
  logic [1:0]       ft_q;              // [0] ch a, [1] ch b feed-through
  rp_pkg::sample_t  ft_a, ft_b;
  rp_pkg::dac_sum_t sum_a, sum_b;
  logic             hit;

  // clip to the signed 14 bit range when the two top bits differ
  function automatic rp_pkg::sample_t saturate(input rp_pkg::dac_sum_t sum);
    if (sum[`RP_ADC_W] != sum[`RP_ADC_W-1])
      saturate = {sum[`RP_ADC_W], {(`RP_ADC_W-1){~sum[`RP_ADC_W]}}};
    else
      saturate = sum[`RP_ADC_W-1:0];
  endfunction

  assign hit = (bus.offs == `RP_DAC_LVL_A_OFS) || (bus.offs == `RP_DAC_LVL_B_OFS) ||
               (bus.offs == `RP_DAC_FT_OFS);

  // --------------------
  // registers
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
      lvl_a_q <= '0;
      lvl_b_q <= '0;
      ft_q    <= '0;
    end else begin
      bus.ack <= bus.wen | bus.ren;
      bus.err <= (bus.wen | bus.ren) & ~hit;
      if (bus.wen) begin
        case (bus.offs)
          `RP_DAC_LVL_A_OFS: lvl_a_q <= bus.wdata[`RP_ADC_W-1:0];
          `RP_DAC_LVL_B_OFS: lvl_b_q <= bus.wdata[`RP_ADC_W-1:0];
          `RP_DAC_FT_OFS:    ft_q    <= bus.wdata[1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      case (bus.offs)  // levels read back sign extended
        `RP_DAC_LVL_A_OFS: bus.rdata <= {{(`RP_DATA_W-`RP_ADC_W){lvl_a_q[`RP_ADC_W-1]}}, lvl_a_q};
        `RP_DAC_LVL_B_OFS: bus.rdata <= {{(`RP_DATA_W-`RP_ADC_W){lvl_b_q[`RP_ADC_W-1]}}, lvl_b_q};
        `RP_DAC_FT_OFS:    bus.rdata <= {{(`RP_DATA_W-2){1'b0}}, ft_q};
        default:           bus.rdata <= '0;
      endcase
    end
  end

  // --------------------
  // summing point, level stands in for the generator
  assign ft_a  = ft_q[0] ? adc_a_i : rp_pkg::sample_t'(0);
  assign ft_b  = ft_q[1] ? adc_b_i : rp_pkg::sample_t'(0);
  assign sum_a = rp_pkg::dac_sum_t'(lvl_a_q) + rp_pkg::dac_sum_t'(ft_a);
  assign sum_b = rp_pkg::dac_sum_t'(lvl_b_q) + rp_pkg::dac_sum_t'(ft_b);

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dac_a_o <= '0;
      dac_b_o <= '0;
    end else begin
      dac_a_o <= saturate(sum_a);
      dac_b_o <= saturate(sum_b);
    end
  end

  // back to neg slope unsigned code
  assign dac_dat_a_o = {dac_a_o[`RP_ADC_W-1], ~dac_a_o[`RP_ADC_W-2:0]};
  assign dac_dat_b_o = {dac_b_o[`RP_ADC_W-1], ~dac_b_o[`RP_ADC_W-2:0]};

endmodule

//--- common/reg_bus_if.sv
// --------------------
// region bus between the apb decoder and one register slave
// --------------------
`timescale 1ns/100ps

interface reg_bus_if;

  // request, from the decoder
  rp_pkg::reg_offs_t offs;   // byte offset in region
  rp_pkg::reg_data_t wdata;
  logic              wen;    // one cycle strobe
  logic              ren;    // one cycle strobe

  // reply, registered in the slave one cycle after the strobe
  rp_pkg::reg_data_t rdata;
  logic              ack;
  logic              err;    // unmapped offset

  modport dec (output offs, wdata, wen, ren, input rdata, ack, err);
  modport slv (input offs, wdata, wen, ren, output rdata, ack, err);

endinterface

//--- common/rp_defines.svh
// --------------------
// shared widths, register map and region field of the analog board
// --------------------
`ifndef RP_DEFINES_SVH
`define RP_DEFINES_SVH

// data path and bus widths
`define RP_ADC_W   14  // converter sample width
`define RP_DATA_W  32  // register word
`define RP_ADDR_W  32  // apb address
`define RP_OFFS_W  20  // offset inside one region

// region field of the address
`define RP_REG_LSB 20
`define RP_REG_MSB 22

// slow analog
`define RP_PWM_W   8   // duty, one period is 2**8 cycles
`define RP_PWM_N   4

// region 0, housekeeping
`define RP_HK_ID         32'h5250_0001
`define RP_HK_ID_OFS     20'h0_0000
`define RP_HK_LOOP_OFS   20'h0_0004
`define RP_HK_LED_OFS    20'h0_0008

// region 1, dac back end
`define RP_DAC_LVL_A_OFS 20'h0_0000
`define RP_DAC_LVL_B_OFS 20'h0_0004
`define RP_DAC_FT_OFS    20'h0_0008

// region 2, pwm duties at a 4 byte stride
`define RP_AMS_DUTY_OFS  20'h0_0000

`endif

//--- common/rp_pkg.sv
// --------------------
// common types of the analog data path and the register bus
// --------------------
`include "rp_defines.svh"

package rp_pkg;

  // converter side
  typedef logic        [`RP_ADC_W-1:0] adc_code_t;  // unsigned, negative slope
  typedef logic signed [`RP_ADC_W-1:0] sample_t;    // two's complement
  typedef logic signed [`RP_ADC_W:0]   dac_sum_t;   // one guard bit before clipping

  // register bus side
  typedef logic [`RP_DATA_W-1:0]              reg_data_t;
  typedef logic [`RP_OFFS_W-1:0]              reg_offs_t;
  typedef logic [`RP_REG_MSB-`RP_REG_LSB:0]  region_t;

  typedef logic [`RP_PWM_W-1:0] pwm_duty_t;
  typedef logic [7:0]           led_t;

  // apb to region bus sequencer
  typedef enum logic [1:0] {
    DEC_IDLE,    // waiting for a setup phase
    DEC_STROBE,  // wen/ren out to the region
    DEC_RESP     // waiting for ack
  } dec_state_t;

endpackage

//--- flist.f
+incdir+common
common/rp_pkg.sv
common/reg_bus_if.sv
verilog/bus_decoder.sv
verilog/housekeeping.sv
analog/adc_frontend.sv
analog/dac_backend.sv
ams/pwm_gen.sv
ams/ams_regs.sv
verilog/rp_top.sv
tests/tb_rp_top.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f flist.f --top-module tb_rp_top \
  --Mdir obj_dir -o tb_rp_top

./obj_dir/tb_rp_top > sim.log 2>&1 || true

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation passed"
else
  tail -n 20 sim.log
  echo "simulation failed, see sim.log"
  exit 1
fi

//--- tests/tb_rp_top.sv
// --------------------
// testbench of the analog board top: apb registers, adc to dac path, pwm
// --------------------
`timescale 1ns/100ps
`include "rp_defines.svh"

module tb_rp_top;

  localparam int PREADY_TIMEOUT = 16;                          // cycles per transfer
  localparam int FULL_POS       = (1 << (`RP_ADC_W - 1)) - 1;  // +full scale sample
  localparam int FULL_NEG       = -(1 << (`RP_ADC_W - 1));
  localparam int PWM_PERIOD     = 1 << `RP_PWM_W;
  localparam rp_pkg::region_t HK_REG  = 3'd0;
  localparam rp_pkg::region_t DAC_REG = 3'd1;
  localparam rp_pkg::region_t AMS_REG = 3'd2;
  localparam rp_pkg::adc_code_t ZERO_CODE = rp_pkg::adc_code_t'(FULL_POS);  // code of sample 0

  logic                  adc_clk;
  logic                  arst_n_i;
  logic                  psel_i, penable_i, pwrite_i;
  logic [`RP_ADDR_W-1:0] paddr_i;
  rp_pkg::reg_data_t     pwdata_i, prdata_o;
  logic                  pready_o, pslverr_o;
  rp_pkg::adc_code_t     adc_dat_a_i, adc_dat_b_i;
  rp_pkg::adc_code_t     dac_dat_a_o, dac_dat_b_o;
  logic [`RP_PWM_N-1:0]  pwm_o;
  rp_pkg::led_t          led_o;
  logic [31:0]           lcg_state;

  rp_top dut (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .pwm_o       (pwm_o),
    .led_o       (led_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;  // 125 MHz
  end

  // --------------------
  // helpers and reference model
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {lcg_state[15:0], lcg_state[31:16]};  // better bits low
  endfunction

  function automatic logic [`RP_ADDR_W-1:0] reg_addr(input rp_pkg::region_t region,
                                                     input rp_pkg::reg_offs_t offs);
    return {{(`RP_ADDR_W - `RP_REG_MSB - 1){1'b0}}, region, offs};
  endfunction

  // negative slope: code 0 is +full scale, one lsb down per code step
  function automatic int code_to_int(input rp_pkg::adc_code_t code);
    return FULL_POS - int'(code);
  endfunction

  function automatic rp_pkg::adc_code_t int_to_code(input int s);
    return rp_pkg::adc_code_t'(FULL_POS - s);
  endfunction

  function automatic int clip14(input int v);
    if (v > FULL_POS) return FULL_POS;
    if (v < FULL_NEG) return FULL_NEG;
    return v;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input rp_pkg::reg_data_t got,
                            input rp_pkg::reg_data_t exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] time %0d ns, %s: got 0x%h, expected 0x%h",
                          $time, name, got, exp));
  endtask

  task automatic check_code(input string name, input rp_pkg::adc_code_t got,
                            input rp_pkg::adc_code_t exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] time %0d ns, %s: got 0x%h, expected 0x%h",
                          $time, name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      abort_run($sformatf("[FAIL] time %0d ns, %s: got %0d, expected %0d",
                          $time, name, got, exp));
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] time %0d ns, %s: got %b, expected %b",
                          $time, name, got, exp));
  endtask

  // --------------------
  // apb master, setup on one falling edge, access from the next
  task automatic apb_xfer(input logic wr, input logic [`RP_ADDR_W-1:0] addr,
                          input rp_pkg::reg_data_t wdata, output rp_pkg::reg_data_t rdata,
                          output logic err);
    int cyc;
    @(negedge adc_clk);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge adc_clk);
    penable_i = 1'b1;
    cyc = 0;
    do begin
      @(negedge adc_clk);
      cyc++;
    end while (!pready_o && cyc < PREADY_TIMEOUT);
    if (!pready_o)
      abort_run($sformatf("timeout: no pready_o within %0d cycles, address 0x%h", cyc, addr));
    rdata     = prdata_o;
    err       = pslverr_o;
    psel_i    = 1'b0;  // back to idle on the same edge
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input logic [`RP_ADDR_W-1:0] addr, input rp_pkg::reg_data_t data);
    rp_pkg::reg_data_t unused;
    logic              err;
    apb_xfer(1'b1, addr, data, unused, err);
    check_err("pslverr_o", err, 1'b0);  // every write here is mapped
  endtask

  task automatic apb_read(input logic [`RP_ADDR_W-1:0] addr, output rp_pkg::reg_data_t data,
                          output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  task automatic drive_adc(input rp_pkg::adc_code_t code_a, input rp_pkg::adc_code_t code_b);
    @(negedge adc_clk);
    adc_dat_a_i = code_a;
    adc_dat_b_i = code_b;
    repeat (4) @(negedge adc_clk);  // 2 cycle path, then settled
  endtask

  // --------------------
  // directed tests
  task automatic test_registers();
    rp_pkg::reg_data_t rd;
    logic              err;
    rp_pkg::led_t      leds;
    apb_read(reg_addr(HK_REG, `RP_HK_ID_OFS), rd, err);
    check_data("prdata_o", rd, `RP_HK_ID);
    check_err("pslverr_o", err, 1'b0);
    leds = rp_pkg::led_t'(lcg_next());
    apb_write(reg_addr(HK_REG, `RP_HK_LED_OFS), {24'd0, leds});
    apb_read(reg_addr(HK_REG, `RP_HK_LED_OFS), rd, err);
    check_data("prdata_o", rd, {24'd0, leds});
    check_data("led_o", {24'd0, led_o}, {24'd0, leds});
    apb_read(reg_addr(3'd3, 20'h0_0010), rd, err);  // unused regions
    check_data("prdata_o", rd, '0);
    check_err("pslverr_o", err, 1'b0);
    apb_read(reg_addr(3'd7, 20'h0_0000), rd, err);
    check_data("prdata_o", rd, '0);
    check_err("pslverr_o", err, 1'b0);
    apb_read(reg_addr(HK_REG, 20'h0_000C), rd, err);  // hole in region 0
    check_err("pslverr_o", err, 1'b1);
    check_data("prdata_o", rd, '0);
  endtask

  task automatic test_feedthrough();
    rp_pkg::adc_code_t code_a, code_b;
    apb_write(reg_addr(DAC_REG, `RP_DAC_LVL_A_OFS), '0);
    apb_write(reg_addr(DAC_REG, `RP_DAC_LVL_B_OFS), '0);
    apb_write(reg_addr(DAC_REG, `RP_DAC_FT_OFS), 32'd3);  // both channels
    for (int i = 0; i < 8; i++) begin
      code_a = rp_pkg::adc_code_t'(lcg_next());
      code_b = rp_pkg::adc_code_t'(lcg_next());
      drive_adc(code_a, code_b);
      check_code("dac_dat_a_o", dac_dat_a_o, code_a);  // zero level gives the same code
      check_code("dac_dat_b_o", dac_dat_b_o, code_b);
    end
  endtask

  task automatic test_level();
    int                lvl_a, lvl_b;
    rp_pkg::adc_code_t code_a, code_b;
    rp_pkg::reg_data_t rd;
    logic              err;
    lvl_a = int'(lcg_next() % 32'd16384) + FULL_NEG;  // any 14 bit level
    lvl_b = int'(lcg_next() % 32'd16384) + FULL_NEG;
    apb_write(reg_addr(DAC_REG, `RP_DAC_LVL_A_OFS), rp_pkg::reg_data_t'(lvl_a));
    apb_write(reg_addr(DAC_REG, `RP_DAC_LVL_B_OFS), rp_pkg::reg_data_t'(lvl_b));
    apb_write(reg_addr(DAC_REG, `RP_DAC_FT_OFS), 32'd3);
    apb_read(reg_addr(DAC_REG, `RP_DAC_LVL_A_OFS), rd, err);
    check_data("prdata_o", rd, rp_pkg::reg_data_t'(lvl_a));  // sign extended
    for (int i = 0; i < 8; i++) begin
      code_a = rp_pkg::adc_code_t'(lcg_next());
      code_b = rp_pkg::adc_code_t'(lcg_next());
      drive_adc(code_a, code_b);
      check_code("dac_dat_a_o", dac_dat_a_o, int_to_code(clip14(lvl_a + code_to_int(code_a))));
      check_code("dac_dat_b_o", dac_dat_b_o, int_to_code(clip14(lvl_b + code_to_int(code_b))));
    end
    // full scale input pushed further out, must clip
    apb_write(reg_addr(DAC_REG, `RP_DAC_LVL_A_OFS), rp_pkg::reg_data_t'(6000));
    apb_write(reg_addr(DAC_REG, `RP_DAC_LVL_B_OFS), rp_pkg::reg_data_t'(-6000));
    drive_adc(int_to_code(FULL_POS), int_to_code(FULL_NEG));
    check_code("dac_dat_a_o", dac_dat_a_o, int_to_code(FULL_POS));
    check_code("dac_dat_b_o", dac_dat_b_o, int_to_code(FULL_NEG));
  endtask

  task automatic test_digital_loop();
    int lvl;
    lvl = int'(lcg_next() % 32'd1024) + 64;  // positive, settles in < 130 cycles
    // adc pins at -full scale, only the loop path can ramp up to +full scale
    drive_adc(int_to_code(FULL_NEG), int_to_code(FULL_NEG));
    apb_write(reg_addr(DAC_REG, `RP_DAC_FT_OFS), '0);
    apb_write(reg_addr(DAC_REG, `RP_DAC_LVL_A_OFS), rp_pkg::reg_data_t'(lvl));
    apb_write(reg_addr(HK_REG, `RP_HK_LOOP_OFS), 32'd1);
    repeat (4) @(negedge adc_clk);
    check_code("dac_dat_a_o", dac_dat_a_o, int_to_code(lvl));
    apb_write(reg_addr(DAC_REG, `RP_DAC_FT_OFS), 32'd1);  // ch a integrates its level
    repeat (FULL_POS / lvl + 4) @(negedge adc_clk);
    check_code("dac_dat_a_o", dac_dat_a_o, int_to_code(FULL_POS));
    repeat (8) @(negedge adc_clk);
    check_code("dac_dat_a_o", dac_dat_a_o, int_to_code(FULL_POS));  // stays clipped
    apb_write(reg_addr(HK_REG, `RP_HK_LOOP_OFS), '0);
    apb_write(reg_addr(DAC_REG, `RP_DAC_FT_OFS), '0);
  endtask

  task automatic test_pwm();
    rp_pkg::pwm_duty_t     duty [`RP_PWM_N];
    int                    high_cnt [`RP_PWM_N];
    rp_pkg::reg_data_t     rd;
    logic                  err;
    logic [`RP_ADDR_W-1:0] addr;
    for (int ch = 0; ch < `RP_PWM_N; ch++) begin
      duty[ch] = rp_pkg::pwm_duty_t'(lcg_next());
      addr = reg_addr(AMS_REG, rp_pkg::reg_offs_t'(4 * ch) + `RP_AMS_DUTY_OFS);
      apb_write(addr, {24'd0, duty[ch]});
      apb_read(addr, rd, err);
      check_data("prdata_o", rd, {24'd0, duty[ch]});
      high_cnt[ch] = 0;
    end
    repeat (2 * PWM_PERIOD) @(negedge adc_clk);  // new duty taken at wrap
    for (int n = 0; n < PWM_PERIOD; n++) begin
      @(negedge adc_clk);
      for (int ch = 0; ch < `RP_PWM_N; ch++)
        if (pwm_o[ch]) high_cnt[ch]++;
    end
    for (int ch = 0; ch < `RP_PWM_N; ch++)
      check_count($sformatf("pwm_o[%0d] high cycles", ch), high_cnt[ch], int'(duty[ch]));
  endtask

  // --------------------
  // main sequence
  initial begin
    lcg_state   = 32'd68129;
    arst_n_i    = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    adc_dat_a_i = ZERO_CODE;
    adc_dat_b_i = ZERO_CODE;
    repeat (8) @(negedge adc_clk);
    check_err("pready_o", pready_o, 1'b0);  // reset values
    check_err("pslverr_o", pslverr_o, 1'b0);
    check_code("dac_dat_a_o", dac_dat_a_o, ZERO_CODE);
    check_code("dac_dat_b_o", dac_dat_b_o, ZERO_CODE);
    check_data("led_o", {24'd0, led_o}, '0);
    check_count("pwm_o", int'(pwm_o), 0);
    arst_n_i = 1'b1;
    repeat (2) @(negedge adc_clk);
    test_registers();
    test_feedthrough();
    test_level();
    test_digital_loop();
    test_pwm();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- verilog/bus_decoder.sv
// --------------------
// apb slave, splits the address into 8 regions and runs the region bus
// --------------------
`timescale 1ns/100ps
`include "rp_defines.svh"

module bus_decoder (
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`RP_ADDR_W-1:0] paddr_i,
  input  rp_pkg::reg_data_t     pwdata_i,
  output rp_pkg::reg_data_t     prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  reg_bus_if.dec                hk_bus,
  reg_bus_if.dec                dac_bus,
  reg_bus_if.dec                ams_bus
);

  localparam rp_pkg::region_t HK_REGION  = rp_pkg::region_t'(0);
  localparam rp_pkg::region_t DAC_REGION = rp_pkg::region_t'(1);
  localparam rp_pkg::region_t AMS_REGION = rp_pkg::region_t'(2);

  rp_pkg::dec_state_t state_q;
  rp_pkg::region_t    region_q;   // latched in setup phase
  rp_pkg::reg_offs_t  offs_q;
  rp_pkg::reg_data_t  wdata_q;
  logic               write_q;
  logic               setup;      // apb setup phase seen in idle
  logic               strobe;
  rp_pkg::reg_data_t  sel_rdata;  // reply of the addressed region
  logic               sel_ack;
  logic               sel_err;

  assign setup  = (state_q == rp_pkg::DEC_IDLE) && psel_i && !penable_i;
  assign strobe = (state_q == rp_pkg::DEC_STROBE);  // first access cycle

  // request side, same offset and data to every region
  assign hk_bus.offs   = offs_q;
  assign hk_bus.wdata  = wdata_q;
  assign hk_bus.wen    = strobe &  write_q & (region_q == HK_REGION);
  assign hk_bus.ren    = strobe & ~write_q & (region_q == HK_REGION);
  assign dac_bus.offs  = offs_q;
  assign dac_bus.wdata = wdata_q;
  assign dac_bus.wen   = strobe &  write_q & (region_q == DAC_REGION);
  assign dac_bus.ren   = strobe & ~write_q & (region_q == DAC_REGION);
  assign ams_bus.offs  = offs_q;
  assign ams_bus.wdata = wdata_q;
  assign ams_bus.wen   = strobe &  write_q & (region_q == AMS_REGION);
  assign ams_bus.ren   = strobe & ~write_q & (region_q == AMS_REGION);

  // reply mux, unused regions answer here with zero data
  always_comb begin
    case (region_q)
      HK_REGION:  {sel_rdata, sel_ack, sel_err} = {hk_bus.rdata, hk_bus.ack, hk_bus.err};
      DAC_REGION: {sel_rdata, sel_ack, sel_err} = {dac_bus.rdata, dac_bus.ack, dac_bus.err};
      AMS_REGION: {sel_rdata, sel_ack, sel_err} = {ams_bus.rdata, ams_bus.ack, ams_bus.err};
      default:    {sel_rdata, sel_ack, sel_err} = {{`RP_DATA_W{1'b0}}, 1'b1, 1'b0};
    endcase
  end

  // --------------------
  // sequencer: idle -> strobe -> resp -> idle with pready out
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= rp_pkg::DEC_IDLE;
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
    end else begin
      pready_o  <= 1'b0;  // single cycle
      pslverr_o <= 1'b0;
      case (state_q)
        rp_pkg::DEC_IDLE:   if (setup) state_q <= rp_pkg::DEC_STROBE;
        rp_pkg::DEC_STROBE: state_q <= rp_pkg::DEC_RESP;
        rp_pkg::DEC_RESP: begin
          if (sel_ack) begin
            pready_o  <= 1'b1;
            pslverr_o <= sel_err;
            state_q   <= rp_pkg::DEC_IDLE;
          end
        end
        default:            state_q <= rp_pkg::DEC_IDLE;
      endcase
    end
  end

  // address, data and reply capture
  always_ff @(posedge adc_clk) begin
    if (setup) begin
      region_q <= paddr_i[`RP_REG_MSB:`RP_REG_LSB];
      offs_q   <= paddr_i[`RP_OFFS_W-1:0];
      wdata_q  <= pwdata_i;
      write_q  <= pwrite_i;
    end
    if (state_q == rp_pkg::DEC_RESP) prdata_o <= sel_rdata;
  end

endmodule

//--- verilog/housekeeping.sv
// --------------------
// housekeeping regs: id word, digital loop switch, leds
// --------------------
`timescale 1ns/100ps
`include "rp_defines.svh"

module housekeeping (
  input  logic         adc_clk,
  input  logic         arst_n_i,
  reg_bus_if.slv       bus,
  output logic         digital_loop_o,  // adc inputs take the dac samples
  output rp_pkg::led_t led_o
);

  logic hit;  // offset is mapped

  assign hit = (bus.offs == `RP_HK_ID_OFS) || (bus.offs == `RP_HK_LOOP_OFS) ||
               (bus.offs == `RP_HK_LED_OFS);

  // control regs and reply flags
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bus.ack        <= 1'b0;
      bus.err        <= 1'b0;
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end else begin
      bus.ack <= bus.wen | bus.ren;      // one cycle after strobe
      bus.err <= (bus.wen | bus.ren) & ~hit;
      if (bus.wen) begin
        case (bus.offs)
          `RP_HK_LOOP_OFS: digital_loop_o <= bus.wdata[0];
          `RP_HK_LED_OFS:  led_o          <= bus.wdata[7:0];
          default: ;                     // id is read only
        endcase
      end
    end
  end

  // read data
  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      case (bus.offs)
        `RP_HK_ID_OFS:   bus.rdata <= `RP_HK_ID;
        `RP_HK_LOOP_OFS: bus.rdata <= {{(`RP_DATA_W-1){1'b0}}, digital_loop_o};
        `RP_HK_LED_OFS:  bus.rdata <= {{(`RP_DATA_W-8){1'b0}}, led_o};
        default:         bus.rdata <= '0;
      endcase
    end
  end

endmodule

//--- verilog/rp_top.sv
// --------------------
// analog board top: apb register port, adc capture, dac back end, pwm
// --------------------
`timescale 1ns/100ps
`include "rp_defines.svh"

module rp_top (
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  // apb slave
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`RP_ADDR_W-1:0] paddr_i,
  input  rp_pkg::reg_data_t     pwdata_i,
  output rp_pkg::reg_data_t     prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // converters
  input  rp_pkg::adc_code_t     adc_dat_a_i,  // ch a raw code
  input  rp_pkg::adc_code_t     adc_dat_b_i,  // ch b raw code
  output rp_pkg::adc_code_t     dac_dat_a_o,
  output rp_pkg::adc_code_t     dac_dat_b_o,
  // slow outputs
  output logic [`RP_PWM_N-1:0]  pwm_o,
  output rp_pkg::led_t          led_o
);

  logic              digital_loop;
  rp_pkg::sample_t   adc_a, adc_b;    // signed adc samples
  rp_pkg::sample_t   dac_a, dac_b;    // clipped dac samples
  rp_pkg::pwm_duty_t duty [`RP_PWM_N];

  reg_bus_if hk_bus  ();  // region 0
  reg_bus_if dac_bus ();  // region 1
  reg_bus_if ams_bus ();  // region 2

  // --------------------
  // register bus
  bus_decoder i_dec (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .hk_bus    (hk_bus),
    .dac_bus   (dac_bus),
    .ams_bus   (ams_bus)
  );

  housekeeping i_hk (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .bus            (hk_bus),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  // --------------------
  // analog path, adc -> dac with optional loop back
  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_a_i        (dac_a),        // loop source
    .dac_b_i        (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  dac_backend i_dac (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .bus         (dac_bus),
    .adc_a_i     (adc_a),
    .adc_b_i     (adc_b),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

  // --------------------
  // slow analog, duty regs and pwm channels
  ams_regs i_ams (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .bus      (ams_bus),
    .duty_o   (duty)
  );

  for (genvar ch = 0; ch < `RP_PWM_N; ch++) begin : g_pwm
    pwm_gen i_pwm (
      .adc_clk  (adc_clk),
      .arst_n_i (arst_n_i),
      .duty_i   (duty[ch]),
      .pwm_o    (pwm_o[ch])
    );
  end

endmodule
